/* files.f */
hw/rv_core_pkg.sv
hw/rv_fetch.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_core.sv
verif/rv_core_asserts.sv
verif/rv_core_tb.sv

/* hw/rv_core.sv */
`timescale 1ns/1ns

module rv_core import rv_core_pkg::*; #(
    parameter word_t RESET_PC = rv_core_pkg::RESET_PC
) (
    input  logic  CLK,
    input  logic  RESET,
    input  word_t instr_i,        // returned combinationally for pc_o
    output word_t pc_o,
    output logic  dmem_we_o,      // sw in this cycle, written on the closing edge
    output word_t dmem_addr_o,
    output word_t dmem_wdata_o,
    output logic  illegal_instr_o
);

    //////////////////////////////
    // internal nets

    word_t     pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic      rf_we;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    alu_op_e   alu_op;
    word_t     imm;
    logic      is_branch;
    logic      is_jal;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     result;        // write-back value or store address
    logic      redirect;
    word_t     branch_offset;

    //////////////////////////////
    // datapath

    rv_fetch #(
        .RESET_PC        (RESET_PC)
    ) u_fetch (
        .CLK             (CLK),
        .RESET           (RESET),
        .redirect_i      (redirect),
        .branch_offset_i (branch_offset),
        .pc_o            (pc)
    );

    rv_decoder u_decoder (
        .instr_i     (instr_u'(instr_i)), // raw word, the decoder picks the view
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rd_addr_o   (rd_addr),
        .rf_we_o     (rf_we),
        .op_a_sel_o  (op_a_sel),
        .op_b_sel_o  (op_b_sel),
        .alu_op_o    (alu_op),
        .imm_o       (imm),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .store_o     (dmem_we_o),
        .illegal_o   (illegal_instr_o)
    );

    rv_regfile u_regfile (
        .CLK        (CLK),
        .RESET      (RESET),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .we_i       (rf_we),
        .wdata_i    (result),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_execute u_execute (
        .pc_i            (pc),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .imm_i           (imm),
        .op_a_sel_i      (op_a_sel),
        .op_b_sel_i      (op_b_sel),
        .alu_op_i        (alu_op),
        .is_branch_i     (is_branch),
        .is_jal_i        (is_jal),
        .result_o        (result),
        .redirect_o      (redirect),
        .branch_offset_o (branch_offset)
    );

    assign pc_o         = pc;
    assign dmem_addr_o  = result;   // rs1 + S offset for sw
    assign dmem_wdata_o = rs2_data;

endmodule

/* hw/rv_core_pkg.sv */
package rv_core_pkg;

    //////////////////////////////
    // widths and base types

    localparam int XLEN       = 32; // data and address width
    localparam int REG_ADDR_W = 5;  // 32 architectural registers

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = '0; // first fetch address after reset

    //////////////////////////////
    // major opcodes kept by this core

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // register-register alu
        OPC_OP_IMM = 7'b0010011, // register-immediate alu
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_STORE  = 7'b0100011  // sw only
    } opcode_e;

    // arithmetic and logic codes first, then the branch compares
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_EQ,
        ALU_NE,
        ALU_LT,
        ALU_GE,
        ALU_LTU,
        ALU_GEU
    } alu_op_e;

    typedef enum logic {
        OP_A_RS1,  // register rs1
        OP_A_ZERO  // lui and jal
    } op_a_sel_e;

    typedef enum logic [2:0] {
        OP_B_RS2,
        OP_B_IMM_I,
        OP_B_IMM_U,
        OP_B_IMM_S,
        OP_B_FOUR  // link value for jal
    } op_b_sel_e;

    //////////////////////////////
    // instruction formats, msb first

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;    // shamt lives in imm[4:0] for shifts
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, seen through whichever format its opcode picks
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

/* hw/rv_decoder.sv */
`timescale 1ns/1ns

module rv_decoder import rv_core_pkg::*; (
    input  instr_u    instr_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output reg_addr_t rd_addr_o,
    output logic      rf_we_o,
    output op_a_sel_e op_a_sel_o,
    output op_b_sel_e op_b_sel_o,
    output alu_op_e   alu_op_o,
    output word_t     imm_o,       // sign extended, format follows the opcode
    output logic      is_branch_o,
    output logic      is_jal_o,
    output logic      store_o,
    output logic      illegal_o
);

    word_t imm_i_ext;
    word_t imm_s_ext;
    word_t imm_b_ext; // byte offset, bit 0 always zero
    word_t imm_u_ext;
    word_t imm_j_ext;
    logic  funct7_ok; // base or alternate encoding
    logic  illegal;   // raw verdict before side effects are gated

    // funct3 to alu code for OP and OP_IMM, alt picks sub and sra
    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // register fields sit at the same place in every format that has them
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;
    assign rd_addr_o  = instr_i.r.rd;

    //////////////////////////////
    // immediates per format

    assign imm_i_ext = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s_ext = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
    assign imm_b_ext = {{20{instr_i.b.imm_12}}, instr_i.b.imm_11, instr_i.b.imm_10_5,
                        instr_i.b.imm_4_1, 1'b0};
    assign imm_u_ext = {instr_i.u.imm_31_12, 12'b0}; // low bits zero, no extension
    assign imm_j_ext = {{12{instr_i.j.imm_20}}, instr_i.j.imm_19_12, instr_i.j.imm_11,
                        instr_i.j.imm_10_1, 1'b0};

    assign funct7_ok = (instr_i.r.funct7 == 7'b0000000) || (instr_i.r.funct7 == 7'b0100000);

    //////////////////////////////
    // control decode

    always_comb begin
        rf_we_o     = 1'b0;
        op_a_sel_o  = OP_A_RS1;
        op_b_sel_o  = OP_B_RS2;
        alu_op_o    = ALU_ADD;
        imm_o       = '0;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        store_o     = 1'b0;
        illegal     = 1'b0;
        case (instr_i.r.opcode)
            OPC_OP: begin
                rf_we_o  = 1'b1;
                alu_op_o = arith_op(instr_i.r.funct3, instr_i.r.funct7[5]);
                illegal  = !funct7_ok;
            end
            OPC_OP_IMM: begin
                rf_we_o    = 1'b1;
                op_b_sel_o = OP_B_IMM_I;
                imm_o      = imm_i_ext;
                // only the shifts carry a funct7 in the upper immediate bits
                if (instr_i.i.funct3 == 3'b001 || instr_i.i.funct3 == 3'b101) begin
                    alu_op_o = arith_op(instr_i.r.funct3, instr_i.r.funct7[5]);
                    illegal  = !funct7_ok;
                end else begin
                    alu_op_o = arith_op(instr_i.i.funct3, 1'b0); // there is no subi
                end
            end
            OPC_LUI: begin
                rf_we_o    = 1'b1;
                op_a_sel_o = OP_A_ZERO; // 0 + imm
                op_b_sel_o = OP_B_IMM_U;
                imm_o      = imm_u_ext;
            end
            OPC_BRANCH: begin
                is_branch_o = 1'b1;
                imm_o       = imm_b_ext; // consumed as the target offset
                case (instr_i.b.funct3)
                    3'b000:  alu_op_o = ALU_EQ;
                    3'b001:  alu_op_o = ALU_NE;
                    3'b100:  alu_op_o = ALU_LT;
                    3'b101:  alu_op_o = ALU_GE;
                    3'b110:  alu_op_o = ALU_LTU;
                    3'b111:  alu_op_o = ALU_GEU;
                    default: illegal  = 1'b1; // 010 and 011 are unassigned
                endcase
            end
            OPC_JAL: begin
                rf_we_o    = 1'b1;
                is_jal_o   = 1'b1;
                op_a_sel_o = OP_A_ZERO; // execute adds the pc to get the link
                op_b_sel_o = OP_B_FOUR;
                imm_o      = imm_j_ext;
            end
            OPC_STORE: begin
                store_o    = 1'b1;
                op_b_sel_o = OP_B_IMM_S; // rs1 + offset is the address
                imm_o      = imm_s_ext;
                illegal    = instr_i.s.funct3 != 3'b010; // sb and sh are not supported
            end
            default: illegal = 1'b1; // loads, jalr, auipc, fence, system
        endcase

        // a rejected word behaves as a plain pc + 4
        if (illegal) begin
            rf_we_o     = 1'b0;
            store_o     = 1'b0;
            is_branch_o = 1'b0;
            is_jal_o    = 1'b0;
        end
    end

    assign illegal_o = illegal;

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ns

module rv_execute import rv_core_pkg::*; (
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  word_t     imm_i,
    input  op_a_sel_e op_a_sel_i,
    input  op_b_sel_e op_b_sel_i,
    input  alu_op_e   alu_op_i,
    input  logic      is_branch_i,
    input  logic      is_jal_i,
    output word_t     result_o,        // rd value, also the store address
    output logic      redirect_o,
    output word_t     branch_offset_o
);

    word_t      op_a;
    word_t      op_b;
    word_t      alu_res;
    logic       cmp_flag; // branch condition and slt result
    logic [4:0] shamt;    // shifts use only the low five bits

    //////////////////////////////
    // operand select

    assign op_a = (op_a_sel_i == OP_A_ZERO) ? '0 : rs1_data_i;

    always_comb begin
        case (op_b_sel_i)
            OP_B_RS2:                           op_b = rs2_data_i;
            // the decoder has already shaped imm_i for the format
            OP_B_IMM_I, OP_B_IMM_U, OP_B_IMM_S: op_b = imm_i;
            OP_B_FOUR:                          op_b = XLEN'(4);
            default:                            op_b = rs2_data_i; // unused encodings
        endcase
    end

    assign shamt = op_b[4:0];

    //////////////////////////////
    // compare and alu

    always_comb begin
        case (alu_op_i)
            ALU_EQ:            cmp_flag = op_a == op_b;
            ALU_NE:            cmp_flag = op_a != op_b;
            ALU_LT, ALU_SLT:   cmp_flag = $signed(op_a) < $signed(op_b);
            ALU_GE:            cmp_flag = $signed(op_a) >= $signed(op_b);
            ALU_LTU, ALU_SLTU: cmp_flag = op_a < op_b;
            ALU_GEU:           cmp_flag = op_a >= op_b;
            default:           cmp_flag = 1'b0;
        endcase
    end

    always_comb begin
        case (alu_op_i)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_SLL: alu_res = op_a << shamt;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SRL: alu_res = op_a >> shamt;
            ALU_SRA: alu_res = $unsigned($signed(op_a) >>> shamt); // sign fill
            ALU_OR:  alu_res = op_a | op_b;
            ALU_AND: alu_res = op_a & op_b;
            default: alu_res = {{(XLEN-1){1'b0}}, cmp_flag}; // slt(u) and compares
        endcase
    end

    // jal link is 0 + 4 from the alu, the pc is folded in here
    assign result_o = is_jal_i ? (pc_i + alu_res) : alu_res;

    //////////////////////////////
    // redirect

    assign redirect_o      = is_jal_i || (is_branch_i && cmp_flag);
    assign branch_offset_o = imm_i; // B or J offset, picked by the decoder

endmodule

/* hw/rv_fetch.sv */
`timescale 1ns/1ns

module rv_fetch import rv_core_pkg::*; #(
    parameter word_t RESET_PC = rv_core_pkg::RESET_PC
) (
    input  logic  CLK,
    input  logic  RESET,
    input  logic  redirect_i,      // taken branch or jal
    input  word_t branch_offset_i, // pc-relative, already sign extended
    output word_t pc_o
);

    //////////////////////////////
    // program counter

    word_t pc_q;    // address of the instruction executing now
    word_t pc_step; // amount added on the coming edge
    word_t pc_next;

    // sequential flow is one word, any redirect is relative to this pc
    assign pc_step = redirect_i ? branch_offset_i : XLEN'(4);
    assign pc_next = pc_q + pc_step;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next; // every cycle retires one instruction
        end
    end

    assign pc_o = pc_q; // goes straight to the instruction port

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile import rv_core_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  reg_addr_t rd_addr_i,
    input  logic      we_i,
    input  word_t     wdata_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs_q [1:31]; // x1..x31, x0 has no storage

    //////////////////////////////
    // write port

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int k = 1; k < 32; k++) begin
                regs_q[k] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin // x0 writes dropped
            regs_q[rd_addr_i] <= wdata_i;
        end
    end

    //////////////////////////////
    // read ports, combinational

    // new data is visible only after the edge, no bypass needed in one cycle
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
SIM=rv_core_sim

verilator --binary --timing --assert -j 0 \
    --top-module rv_core_tb \
    -f files.f \
    -Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM" 2>&1 | tee "$LOG"
run_status=${PIPESTATUS[0]}
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "failure reported, see $LOG"
    exit 1
fi

echo "no failure reported in $LOG"
exit 0

/* verif/rv_core_asserts.sv */
`timescale 1ns/1ns

module rv_core_asserts import rv_core_pkg::*; #(
    parameter word_t RESET_PC = rv_core_pkg::RESET_PC
) (
    input logic  CLK,
    input logic  RESET,
    input word_t pc_o,
    input logic  dmem_we_o,
    input logic  illegal_instr_o
);

    //////////////////////////////
    // port properties

    // every step is four or an even offset with bit 1 clear in practice
    pc_aligned: assert property (@(posedge CLK) disable iff (RESET) pc_o[1:0] == 2'b00)
        else $error("pc_o not word aligned: %h", pc_o);

    // a rejected word never reaches the data memory
    store_not_illegal: assert property (@(posedge CLK) !(dmem_we_o && illegal_instr_o))
        else $error("store raised together with illegal_instr_o at pc %h", pc_o);

    reset_pc: assert property (@(posedge CLK) RESET |=> pc_o == RESET_PC)
        else $error("pc_o is %h after reset, not the reset address", pc_o);

endmodule

bind rv_core rv_core_asserts #(.RESET_PC(RESET_PC)) u_asserts (
    .CLK             (CLK),
    .RESET           (RESET),
    .pc_o            (pc_o),
    .dmem_we_o       (dmem_we_o),
    .illegal_instr_o (illegal_instr_o)
);

/* verif/rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb import rv_core_pkg::*; ();

    localparam word_t NOP         = 32'h0000_0013; // addi x0, x0, 0
    localparam word_t HALT        = 32'h0000_006F; // jal x0, 0 spins in place
    localparam word_t X1_VAL      = 32'hFFFF_FFFB; // -5, branch operand
    localparam word_t X2_VAL      = 32'd3;
    localparam int    IMEM_WORDS  = 256;           // 1 KiB, pc bits 9:2
    localparam int    TIMEOUT     = 1000;          // cycles per wait
    localparam int    TRACE_DEPTH = 64;

    logic  CLK     = 1'b0;
    logic  RESET   = 1'b1;
    word_t instr_i = NOP;
    word_t pc_o;
    logic  dmem_we_o;
    word_t dmem_addr_o;
    word_t dmem_wdata_o;
    logic  illegal_instr_o;

    logic  rst_cmd = 1'b1; // set on a rising edge, applied on the falling one
    word_t imem [0:IMEM_WORDS-1];
    word_t prog [$];       // program under construction
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t st_addr [$];    // store log
    word_t st_data [$];
    word_t trace_pc [$];   // first cycles after reset
    logic  trace_ill [$];
    word_t lcg_state;
    int    errors;
    int    timeouts;

    rv_core #(
        .RESET_PC        (RESET_PC)
    ) u_dut (
        .CLK             (CLK),
        .RESET           (RESET),
        .instr_i         (instr_i),
        .pc_o            (pc_o),
        .dmem_we_o       (dmem_we_o),
        .dmem_addr_o     (dmem_addr_o),
        .dmem_wdata_o    (dmem_wdata_o),
        .illegal_instr_o (illegal_instr_o)
    );

    always #10 CLK = ~CLK; // 20 ns period

    //////////////////////////////
    // instruction port and store monitor

    function automatic word_t imem_read(input word_t addr);
        if ($isunknown(addr) || addr[31:10] != '0) begin
            return NOP; // outside the memory
        end
        return imem[addr[9:2]];
    endfunction

    always @(negedge CLK) begin
        RESET   <= rst_cmd;
        instr_i <= rst_cmd ? NOP : imem_read(pc_o); // nop at RESET_PC during reset
    end

    always @(posedge CLK) begin
        if (RESET) begin // logs restart with every reset
            st_addr.delete();
            st_data.delete();
            trace_pc.delete();
            trace_ill.delete();
        end else begin
            if (trace_pc.size() < TRACE_DEPTH) begin
                trace_pc.push_back(pc_o);
                trace_ill.push_back(illegal_instr_o);
            end
            if (dmem_we_o) begin
                st_addr.push_back(dmem_addr_o);
                st_data.push_back(dmem_wdata_o);
            end
        end
    end

    //////////////////////////////
    // encoding and reference models

    function automatic word_t r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_word(input logic [6:0] opc, input logic [4:0] rd,
                                     input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // rs2 is the data, rs1 the base
    function automatic word_t store_word(input logic [2:0] f3, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        word_t res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0]; // sign bit shifted in
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t lcg_word();
        word_t hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi        = lcg_state;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi[31:16], lcg_state[31:16]}; // low lcg bits cycle too fast
    endfunction

    function automatic void emit(input word_t w);
        prog.push_back(w);
    endfunction

    // lui + addi, upper part rounded so the signed low part lands exactly
    function automatic void load_value(input logic [4:0] rd, input word_t v);
        word_t hi;
        hi = (v + 32'h800) >> 12;
        emit(lui_word(rd, hi[19:0]));
        emit(i_word(7'b0010011, rd, 3'b000, rd, v[11:0]));
    endfunction

    function automatic void expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endfunction

    function automatic void new_test();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endfunction

    //////////////////////////////
    // checks and sequencing

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_stores(input string name);
        int n;
        n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
        if (st_addr.size() != exp_addr.size()) begin
            errors++;
            $display("ERROR: %s made %0d stores where %0d were expected",
                     name, st_addr.size(), exp_addr.size());
        end
        for (int k = 0; k < n; k++) begin
            check_word($sformatf("%s store %0d addr", name, k), exp_addr[k], st_addr[k]);
            check_word($sformatf("%s store %0d data", name, k), exp_data[k], st_data[k]);
        end
    endtask

    // four rising edges with RESET high, program copied in meanwhile
    task automatic reset_and_load();
        @(posedge CLK);
        rst_cmd = 1'b1;
        @(posedge CLK);
        for (int k = 0; k < IMEM_WORDS; k++) begin
            imem[k] = (k < prog.size()) ? prog[k] : NOP;
        end
        repeat (3) @(posedge CLK);
        rst_cmd = 1'b0;
    endtask

    task automatic wait_stores(input string name, input int n);
        int cycles;
        cycles = 0;
        while (st_addr.size() < n && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (st_addr.size() < n) begin
            timeouts++;
            $display("ERROR: %s timed out after %0d cycles with %0d of %0d stores",
                     name, cycles, st_addr.size(), n);
        end
    endtask

    task automatic run_program(input string name);
        reset_and_load();
        wait_stores(name, exp_addr.size());
        repeat (4) @(negedge CLK); // a stray extra store would show up here
        check_stores(name);
    endtask

    //////////////////////////////
    // tests

    task automatic test_alu(input int round);
        word_t       a;
        word_t       b;
        word_t       rnd;
        logic [11:0] imm;
        int          k;
        new_test();
        a = lcg_word();
        b = lcg_word();
        load_value(5'd1, a);
        load_value(5'd2, b);
        k = 0;
        for (int f = 0; f < 8; f++) begin // register forms, alt is sub and sra
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 0 || f == 5) begin
                    emit(r_word((alt != 0) ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, 3'(f), 5'd3));
                    emit(store_word(3'b010, 5'd3, 5'd0, 12'(256 + 4 * k)));
                    expect_store(word_t'(256 + 4 * k), alu_model(3'(f), alt[0], a, b));
                    k++;
                end
            end
        end
        for (int f = 0; f < 8; f++) begin // immediate forms, only srai has alt
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 5) begin
                    rnd = lcg_word();
                    imm = (f == 1 || f == 5) ?
                          {(alt != 0) ? 7'b0100000 : 7'b0000000, rnd[4:0]} : rnd[11:0];
                    emit(i_word(7'b0010011, 5'd3, 3'(f), 5'd1, imm));
                    emit(store_word(3'b010, 5'd3, 5'd0, 12'(256 + 4 * k)));
                    expect_store(word_t'(256 + 4 * k),
                                 alu_model(3'(f), alt[0], a, {{20{imm[11]}}, imm}));
                    k++;
                end
            end
        end
        emit(HALT);
        run_program($sformatf("alu round %0d", round));
    endtask

    task automatic test_lui_sext();
        new_test();
        emit(lui_word(5'd5, 20'hABCDE));
        emit(store_word(3'b010, 5'd5, 5'd0, 12'h040));
        emit(i_word(7'b0010011, 5'd6, 3'b000, 5'd0, 12'hFFF)); // addi x6, x0, -1
        emit(store_word(3'b010, 5'd6, 5'd0, 12'h044));
        emit(i_word(7'b0010011, 5'd7, 3'b000, 5'd0, 12'h800)); // most negative imm
        emit(store_word(3'b010, 5'd7, 5'd0, 12'h048));
        emit(HALT);
        expect_store(32'h040, {20'hABCDE, 12'h000});
        expect_store(32'h044, {{20{1'b1}}, 12'hFFF});
        expect_store(32'h048, {{20{1'b1}}, 12'h800});
        run_program("lui and sign extension");
    endtask

    // each case: branch over a marker store, then an always-taken store
    task automatic test_branches();
        logic [2:0] f3;
        logic [4:0] rs1;
        logic [4:0] rs2;
        int         k;
        new_test();
        emit(i_word(7'b0010011, 5'd1, 3'b000, 5'd0, X1_VAL[11:0]));
        emit(i_word(7'b0010011, 5'd2, 3'b000, 5'd0, X2_VAL[11:0]));
        emit(i_word(7'b0010011, 5'd10, 3'b000, 5'd0, 12'h011)); // marker data
        emit(i_word(7'b0010011, 5'd11, 3'b000, 5'd0, 12'h022));
        k = 0;
        for (int bi = 0; bi < 6; bi++) begin
            f3 = (bi < 2) ? 3'(bi) : 3'(bi + 2); // skips 010 and 011
            for (int p = 0; p < 3; p++) begin   // (x1,x2) (x2,x1) (x1,x1)
                rs1 = (p == 1) ? 5'd2 : 5'd1;
                rs2 = (p == 0) ? 5'd2 : 5'd1;
                emit(branch_word(f3, rs1, rs2, 13'd8));
                emit(store_word(3'b010, 5'd10, 5'd0, 12'(512 + 8 * k)));
                emit(store_word(3'b010, 5'd11, 5'd0, 12'(516 + 8 * k)));
                if (!branch_model(f3, (rs1 == 5'd1) ? X1_VAL : X2_VAL,
                                  (rs2 == 5'd1) ? X1_VAL : X2_VAL)) begin
                    expect_store(word_t'(512 + 8 * k), 32'h11);
                end
                expect_store(word_t'(516 + 8 * k), 32'h22);
                k++;
            end
        end
        emit(HALT);
        run_program("branches");
    endtask

    task automatic test_jal();
        new_test();
        emit(i_word(7'b0010011, 5'd1, 3'b000, 5'd0, 12'd7)); // 0x00
        emit(jal_word(5'd5, 21'd12));                       // 0x04, lands on 0x10
        emit(store_word(3'b010, 5'd1, 5'd0, 12'h300));       // skipped
        emit(store_word(3'b010, 5'd1, 5'd0, 12'h304));       // skipped
        emit(store_word(3'b010, 5'd5, 5'd0, 12'h308));       // 0x10
        emit(store_word(3'b010, 5'd1, 5'd0, 12'h30C));
        emit(HALT);
        expect_store(32'h308, 32'h4 + 32'd4); // link is the jal address plus four
        expect_store(32'h30C, 32'd7);
        run_program("jal");
    endtask

    task automatic test_illegal();
        new_test();
        emit(i_word(7'b0010011, 5'd1, 3'b000, 5'd0, 12'h055));
        emit(i_word(7'b0000011, 5'd1, 3'b010, 5'd0, 12'h000)); // lw, no load opcode here
        emit(store_word(3'b001, 5'd1, 5'd0, 12'h310));          // sh
        emit(store_word(3'b010, 5'd1, 5'd0, 12'h314));
        emit(HALT);
        expect_store(32'h314, 32'h55); // x1 untouched by the rejected lw
        run_program("illegal");
        if (trace_pc.size() < 4) begin
            errors++;
            $display("ERROR: illegal test traced only %0d cycles", trace_pc.size());
        end else begin
            for (int k = 0; k < 4; k++) begin
                check_word($sformatf("illegal pc %0d", k), word_t'(4 * k), trace_pc[k]);
                check_flag($sformatf("illegal flag %0d", k), (k == 1 || k == 2), trace_ill[k]);
            end
        end
    endtask

    task automatic test_x0_reset();
        new_test();
        emit(store_word(3'b010, 5'd3, 5'd0, 12'h328));          // x3 before any write
        emit(i_word(7'b0010011, 5'd0, 3'b000, 5'd0, 12'h123)); // write to x0
        emit(store_word(3'b010, 5'd0, 5'd0, 12'h320));
        emit(i_word(7'b0010011, 5'd3, 3'b000, 5'd0, 12'h077));
        emit(store_word(3'b010, 5'd3, 5'd0, 12'h324));
        emit(HALT);
        expect_store(32'h328, 32'h0);
        expect_store(32'h320, 32'h0);
        expect_store(32'h324, 32'h77);
        run_program("x0 write");
        // x3 now holds 0x77, the reset must clear it again
        run_program("reset mid-program");
        if (trace_pc.size() == 0) begin
            errors++;
            $display("ERROR: no cycle traced after the mid-program reset");
        end else begin
            check_word("reset pc", RESET_PC, trace_pc[0]);
        end
    endtask

    initial begin
        errors    = 0;
        timeouts  = 0;
        lcg_state = 32'd14899;
        for (int k = 0; k < IMEM_WORDS; k++) begin
            imem[k] = NOP;
        end
        test_alu(0);
        test_alu(1);
        test_lui_sext();
        test_branches();
        test_jal();
        test_illegal();
        test_x0_reset();
        $display("summary: %0d failed checks, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
